// ==== logic/display_defines.svh ====
`ifndef DISPLAY_DEFINES_SVH
`define DISPLAY_DEFINES_SVH

// 640x480 raster, horizontal timing in pixels
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL 800

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL 525

// On-screen keyboard
`define KEY_Y_TOP 370
`define KEY_PITCH 24
`define KEY_WIDTH 22
`define WHITE_X0 11
`define WHITE_LEN 100
`define WHITE_LEN_PRESSED 110
`define BLACK_LEN 50
`define BLACK_LEN_PRESSED 60
`define NUM_WHITE 15
`define NUM_BLACK 11

// Slider track and knob
`define SLIDER_X0 100
`define SLIDER_Y0 300
`define SLIDER_LEN 600
`define SLIDER_THICK 10
`define KNOB_WIDTH 20

// Cursor and marker cell
`define CELL_W 64
`define CELL_H 16

// Palette, 9 bits per channel
`define PAL_BG_R 9'h000
`define PAL_BG_G 9'h000
`define PAL_BG_B 9'h000
`define PAL_BLACK_KEY_R 9'h010
`define PAL_BLACK_KEY_G 9'h020
`define PAL_BLACK_KEY_B 9'h0f0
`define PAL_WHITE_KEY_R 9'h1f0
`define PAL_WHITE_KEY_G 9'h1f0
`define PAL_WHITE_KEY_B 9'h1f0
`define PAL_CURSOR_R 9'h1f0
`define PAL_CURSOR_G 9'h1f0
`define PAL_CURSOR_B 9'h1f0
`define PAL_KNOB_R 9'h100
`define PAL_KNOB_G 9'h130
`define PAL_KNOB_B 9'h1f0
`define PAL_MARKER_R 9'h1ff
`define PAL_MARKER_G 9'h086
`define PAL_MARKER_B 9'h006

`endif

// ==== logic/display_pkg.sv ====
package display_pkg;

	// Pixel or line coordinate
	typedef logic [9:0] coord_t;

	typedef enum logic [1:0] {
		HP_ACTIVE = 2'd0,
		HP_FRONT  = 2'd1,
		HP_SYNC   = 2'd2,
		HP_BACK   = 2'd3
	} h_phase_e;

	typedef enum logic [1:0] {
		VP_ACTIVE = 2'd0,
		VP_FRONT  = 2'd1,
		VP_SYNC   = 2'd2,
		VP_BACK   = 2'd3
	} v_phase_e;

	// Codes 1 and 5 were text layers
	typedef enum logic [2:0] {
		BG        = 3'd0,
		BLACK_KEY = 3'd2,
		WHITE_KEY = 3'd3,
		CURSOR    = 3'd4,
		KNOB      = 3'd6,
		MARKER    = 3'd7
	} color_e;

endpackage

// ==== logic/vga_timing.sv ====
`include "display_defines.svh"

module vga_timing (
	input  logic                VGA_CLK,
	input  logic                reset,
	output display_pkg::coord_t x,
	output display_pkg::coord_t y,
	output logic                h_sync,
	output logic                v_sync,
	output logic                active
);
	import display_pkg::*;

	h_phase_e h_phase;
	v_phase_e v_phase;
	logic     line_end;

	assign line_end = (x == `H_TOTAL - 1);

	// Pixel counter and horizontal phase
	always_ff @(posedge VGA_CLK) begin
		if (reset) begin
			x       <= '0;
			h_phase <= HP_ACTIVE;
		end else begin
			if (line_end)
				x <= '0;
			else
				x <= x + 1'b1;

			case (h_phase)
				HP_ACTIVE: if (x == `H_ACTIVE - 1) h_phase <= HP_FRONT;
				HP_FRONT:  if (x == `H_ACTIVE + `H_FRONT - 1) h_phase <= HP_SYNC;
				HP_SYNC:   if (x == `H_ACTIVE + `H_FRONT + `H_SYNC - 1) h_phase <= HP_BACK;
				HP_BACK:   if (line_end) h_phase <= HP_ACTIVE;
				default:   h_phase <= HP_ACTIVE;
			endcase
		end
	end

	// Line counter, steps once per line
	always_ff @(posedge VGA_CLK) begin
		if (reset) begin
			y       <= '0;
			v_phase <= VP_ACTIVE;
		end else if (line_end) begin
			if (y == `V_TOTAL - 1)
				y <= '0;
			else
				y <= y + 1'b1;

			case (v_phase)
				VP_ACTIVE: if (y == `V_ACTIVE - 1) v_phase <= VP_FRONT;
				VP_FRONT:  if (y == `V_ACTIVE + `V_FRONT - 1) v_phase <= VP_SYNC;
				VP_SYNC:   if (y == `V_ACTIVE + `V_FRONT + `V_SYNC - 1) v_phase <= VP_BACK;
				VP_BACK:   if (y == `V_TOTAL - 1) v_phase <= VP_ACTIVE;
				default:   v_phase <= VP_ACTIVE;
			endcase
		end
	end

	assign h_sync = (h_phase != HP_SYNC); // Active low
	assign v_sync = (v_phase != VP_SYNC);
	assign active = (h_phase == HP_ACTIVE) && (v_phase == VP_ACTIVE);

endmodule

// ==== logic/keyboard_painter.sv ====
`include "display_defines.svh"

module keyboard_painter (
	input  display_pkg::coord_t x,
	input  display_pkg::coord_t y,
	input  logic [7:0]          scan_code1,
	input  logic [7:0]          scan_code2,
	input  logic [7:0]          scan_code3,
	input  logic [7:0]          scan_code4,
	output logic                white_hit,
	output logic                black_hit
);

	localparam int SLOTS = `NUM_WHITE;

	// Scan code per white key, keys 11 to 14 have none
	localparam logic [7:0] WHITE_CODE [SLOTS] = '{
		8'h37, 8'h39, 8'h3b, 8'h3c, 8'h3e, 8'h40, 8'h41, 8'h43,
		8'h45, 8'h47, 8'h48, 8'h00, 8'h00, 8'h00, 8'h00
	};
	localparam logic [SLOTS-1:0] WHITE_HAS_CODE = 15'b000_0111_1111_1111;

	// Black keys by slot, no key at slots 3, 6, 10 and 13
	localparam logic [7:0] BLACK_CODE [SLOTS] = '{
		8'h36, 8'h38, 8'h3a, 8'h00, 8'h3d, 8'h3f, 8'h00, 8'h42,
		8'h44, 8'h46, 8'h00, 8'h49, 8'h00, 8'h00, 8'h00
	};
	localparam logic [SLOTS-1:0] BLACK_PRESENT  = 15'b101_1011_1011_0111;
	localparam logic [SLOTS-1:0] BLACK_HAS_CODE = 15'b000_1011_1011_0111;

	logic [SLOTS-1:0] white_pressed;
	logic [SLOTS-1:0] black_pressed;
	logic             white_cov;
	logic             black_cov;

	// Any of the four voices holding a key's code presses it
	always_comb begin
		for (int n = 0; n < SLOTS; n++) begin
			white_pressed[n] = WHITE_HAS_CODE[n] &&
				(scan_code1 == WHITE_CODE[n] || scan_code2 == WHITE_CODE[n] ||
				 scan_code3 == WHITE_CODE[n] || scan_code4 == WHITE_CODE[n]);
			black_pressed[n] = BLACK_HAS_CODE[n] &&
				(scan_code1 == BLACK_CODE[n] || scan_code2 == BLACK_CODE[n] ||
				 scan_code3 == BLACK_CODE[n] || scan_code4 == BLACK_CODE[n]);
		end
	end

	always_comb begin
		int px;
		int py;
		int left;
		int len;
		px        = int'(x);
		py        = int'(y);
		white_cov = 1'b0;
		black_cov = 1'b0;
		for (int n = 0; n < SLOTS; n++) begin
			// White key n
			left = `WHITE_X0 + n * `KEY_PITCH;
			len  = white_pressed[n] ? `WHITE_LEN_PRESSED : `WHITE_LEN;
			if (px >= left && px < left + `KEY_WIDTH &&
			    py >= `KEY_Y_TOP && py < `KEY_Y_TOP + len)
				white_cov = 1'b1;

			// Black key in slot n, sits half a pitch left of its white key
			left = n * `KEY_PITCH;
			len  = black_pressed[n] ? `BLACK_LEN_PRESSED : `BLACK_LEN;
			if (BLACK_PRESENT[n] && px >= left && px < left + `KEY_WIDTH &&
			    py >= `KEY_Y_TOP && py < `KEY_Y_TOP + len)
				black_cov = 1'b1;
		end
	end

	assign black_hit = black_cov;
	assign white_hit = white_cov && !black_cov; // Black keys drawn on top

endmodule

// ==== logic/slider_painter.sv ====
`include "display_defines.svh"

module slider_painter (
	input  display_pkg::coord_t x,
	input  display_pkg::coord_t y,
	input  logic [7:0]          slide_val,
	output logic                track_hit,
	output logic                knob_hit
);

	logic [17:0] knob_prod;
	logic [11:0] knob_left; // Can run past the raster for large values
	logic [11:0] x_ext;
	logic        in_rows;

	assign knob_prod = 18'(`SLIDER_LEN) * 18'(slide_val);
	assign knob_left = 12'(`SLIDER_X0) + 12'(knob_prod[17:7]); // Scale by 1/128
	assign x_ext     = {2'b00, x};

	assign in_rows = (y >= `SLIDER_Y0) && (y <= `SLIDER_Y0 + `SLIDER_THICK);

	assign track_hit = in_rows && (x >= `SLIDER_X0) && (x <= `SLIDER_X0 + `SLIDER_LEN);

	// Both edges of the knob inclusive
	assign knob_hit = in_rows && (x_ext >= knob_left) &&
		(x_ext <= knob_left + 12'(`KNOB_WIDTH));

endmodule

// ==== logic/overlay_painter.sv ====
`include "display_defines.svh"

module overlay_painter (
	input  display_pkg::coord_t x,
	input  display_pkg::coord_t y,
	input  logic [3:0]          cursor_col,
	input  logic [3:0]          cursor_row,
	input  logic [3:0]          marker_col,
	input  logic [3:0]          marker_row,
	output logic                cursor_hit,
	output logic                marker_hit
);
	import display_pkg::*;

	// Column range half open, row range closed at both ends
	function automatic logic cell_hit(input coord_t px, input coord_t py,
	                                  input logic [3:0] col, input logic [3:0] row);
		logic [10:0] left;
		logic [10:0] right;
		logic [10:0] top;
		logic [10:0] bottom;
		left   = 11'(col) * 11'(`CELL_W);
		right  = left + 11'(`CELL_W);
		top    = 11'(row) * 11'(`CELL_H);
		bottom = top + 11'(`CELL_H);
		return (11'(px) >= left) && (11'(px) < right) &&
		       (11'(py) >= top) && (11'(py) <= bottom);
	endfunction

	assign cursor_hit = cell_hit(x, y, cursor_col, cursor_row);
	assign marker_hit = cell_hit(x, y, marker_col, marker_row);

endmodule

// ==== logic/pixel_mux.sv ====
`include "display_defines.svh"

module pixel_mux (
	input  logic       VGA_CLK,
	input  logic       reset,
	input  logic       h_sync,
	input  logic       v_sync,
	input  logic       active,
	input  logic       white_hit,
	input  logic       black_hit,
	input  logic       track_hit,
	input  logic       knob_hit,
	input  logic       cursor_hit,
	input  logic       marker_hit,
	output logic       hs,
	output logic       vs,
	output logic       de,
	output logic [9:0] vga_r,
	output logic [9:0] vga_g,
	output logic [9:0] vga_b
);
	import display_pkg::*;

	color_e     code;
	logic [8:0] pal_r;
	logic [8:0] pal_g;
	logic [8:0] pal_b;

	// Fixed layer priority, everything blanked outside the active area
	always_comb begin
		if (!active)                     code = BG;
		else if (marker_hit)             code = MARKER;
		else if (knob_hit)               code = KNOB;
		else if (cursor_hit)             code = CURSOR;
		else if (white_hit || track_hit) code = WHITE_KEY; // Track shares key colour
		else if (black_hit)              code = BLACK_KEY;
		else                             code = BG;
	end

	always_comb begin
		case (code)
			BLACK_KEY: {pal_r, pal_g, pal_b} = {`PAL_BLACK_KEY_R, `PAL_BLACK_KEY_G, `PAL_BLACK_KEY_B};
			WHITE_KEY: {pal_r, pal_g, pal_b} = {`PAL_WHITE_KEY_R, `PAL_WHITE_KEY_G, `PAL_WHITE_KEY_B};
			CURSOR:    {pal_r, pal_g, pal_b} = {`PAL_CURSOR_R, `PAL_CURSOR_G, `PAL_CURSOR_B};
			KNOB:      {pal_r, pal_g, pal_b} = {`PAL_KNOB_R, `PAL_KNOB_G, `PAL_KNOB_B};
			MARKER:    {pal_r, pal_g, pal_b} = {`PAL_MARKER_R, `PAL_MARKER_G, `PAL_MARKER_B};
			default:   {pal_r, pal_g, pal_b} = {`PAL_BG_R, `PAL_BG_G, `PAL_BG_B};
		endcase
	end

	// One output stage keeps syncs aligned with colour
	always_ff @(posedge VGA_CLK) begin
		if (reset) begin
			hs    <= 1'b1;
			vs    <= 1'b1;
			de    <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else begin
			hs    <= h_sync;
			vs    <= v_sync;
			de    <= active;
			vga_r <= {1'b0, pal_r};
			vga_g <= {1'b0, pal_g};
			vga_b <= {1'b0, pal_b};
		end
	end

endmodule

// ==== logic/display_top.sv ====
module display_top (
	input  logic       VGA_CLK,
	input  logic       reset,
	input  logic [7:0] scan_code1,
	input  logic [7:0] scan_code2,
	input  logic [7:0] scan_code3,
	input  logic [7:0] scan_code4,
	input  logic [7:0] slide_val,
	input  logic [3:0] cursor_col,
	input  logic [3:0] cursor_row,
	input  logic [3:0] marker_col,
	input  logic [3:0] marker_row,
	output logic       hs,
	output logic       vs,
	output logic       de,
	output logic [9:0] vga_r,
	output logic [9:0] vga_g,
	output logic [9:0] vga_b
);
	import display_pkg::*;

	coord_t x;
	coord_t y;
	logic   h_sync;
	logic   v_sync;
	logic   active;
	logic   white_hit;
	logic   black_hit;
	logic   track_hit;
	logic   knob_hit;
	logic   cursor_hit;
	logic   marker_hit;

	vga_timing u_timing (
		.VGA_CLK (VGA_CLK),
		.reset   (reset),
		.x       (x),
		.y       (y),
		.h_sync  (h_sync),
		.v_sync  (v_sync),
		.active  (active)
	);

	keyboard_painter u_keys (
		.x          (x),
		.y          (y),
		.scan_code1 (scan_code1),
		.scan_code2 (scan_code2),
		.scan_code3 (scan_code3),
		.scan_code4 (scan_code4),
		.white_hit  (white_hit),
		.black_hit  (black_hit)
	);

	slider_painter u_slider (
		.x         (x),
		.y         (y),
		.slide_val (slide_val),
		.track_hit (track_hit),
		.knob_hit  (knob_hit)
	);

	overlay_painter u_overlay (
		.x          (x),
		.y          (y),
		.cursor_col (cursor_col),
		.cursor_row (cursor_row),
		.marker_col (marker_col),
		.marker_row (marker_row),
		.cursor_hit (cursor_hit),
		.marker_hit (marker_hit)
	);

	pixel_mux u_mux (
		.VGA_CLK    (VGA_CLK),
		.reset      (reset),
		.h_sync     (h_sync),
		.v_sync     (v_sync),
		.active     (active),
		.white_hit  (white_hit),
		.black_hit  (black_hit),
		.track_hit  (track_hit),
		.knob_hit   (knob_hit),
		.cursor_hit (cursor_hit),
		.marker_hit (marker_hit),
		.hs         (hs),
		.vs         (vs),
		.de         (de),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b)
	);

endmodule

// ==== verif/display_chk.sv ====
`include "display_defines.svh"

module display_chk (
	input logic                VGA_CLK,
	input logic                reset,
	input display_pkg::coord_t x,
	input display_pkg::coord_t y,
	input logic                h_sync,
	input logic                active
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned sync_len; // Low cycles in the current pulse
	int unsigned fail_count = 0; // Failed assertions

	always_ff @(posedge VGA_CLK) begin
		if (reset)
			sync_len <= 0;
		else if (!h_sync)
			sync_len <= sync_len + 1;
		else
			sync_len <= 0;
	end

	x_in_line: assert property (@(posedge VGA_CLK) disable iff (reset) x < `H_TOTAL)
		else begin
			$error("x counter out of range: %0d", x);
			fail_count++;
		end

	active_in_line: assert property (@(posedge VGA_CLK) disable iff (reset)
		active |-> x < `H_ACTIVE)
		else begin
			$error("active high at x=%0d", x);
			fail_count++;
		end

	// Pulse length checked when sync returns high
	sync_width: assert property (@(posedge VGA_CLK) disable iff (reset)
		$rose(h_sync) |-> sync_len == `H_SYNC)
		else begin
			$error("h_sync low for %0d cycles", sync_len);
			fail_count++;
		end

	reset_clears: assert property (@(posedge VGA_CLK) reset |=> x == 0 && y == 0)
		else begin
			$error("counters not cleared by reset, x=%0d y=%0d", x, y);
			fail_count++;
		end

endmodule

bind vga_timing display_chk u_chk (
	.VGA_CLK (VGA_CLK),
	.reset   (reset),
	.x       (x),
	.y       (y),
	.h_sync  (h_sync),
	.active  (active)
);

// ==== verif/display_tb.sv ====
`include "display_defines.svh"

module display_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import display_pkg::*;

	localparam longint FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int     OFF          = 15; // Cell column past the line end

	typedef struct {
		string  name;
		int     sc1;
		int     sc2;
		int     sc3;
		int     sc4;
		int     slide;
		int     ccol;
		int     crow;
		int     mcol;
		int     mrow;
		int     px;
		int     py;
		color_e exp;
	} probe_t;

	logic       VGA_CLK;
	logic       reset;
	logic [7:0] scan_code1;
	logic [7:0] scan_code2;
	logic [7:0] scan_code3;
	logic [7:0] scan_code4;
	logic [7:0] slide_val;
	logic [3:0] cursor_col;
	logic [3:0] cursor_row;
	logic [3:0] marker_col;
	logic [3:0] marker_row;
	logic       hs;
	logic       vs;
	logic       de;
	logic [9:0] vga_r;
	logic [9:0] vga_g;
	logic [9:0] vga_b;

	longint edge_cnt; // Edges since reset release
	int     errors;
	int     tests_run;
	int     tests_failed;
	probe_t tests[$];

	display_top DUT (.*);

	always #10 VGA_CLK = ~VGA_CLK;

	always @(posedge VGA_CLK) begin
		if (reset)
			edge_cnt <= 0;
		else
			edge_cnt <= edge_cnt + 1;
	end

	task automatic add_test(input string name, input int sc1, input int sc2, input int sc3,
	                        input int sc4, input int slide, input int ccol, input int crow,
	                        input int mcol, input int mrow, input int px, input int py,
	                        input color_e exp);
		probe_t t;
		t = '{name, sc1, sc2, sc3, sc4, slide, ccol, crow, mcol, mrow, px, py, exp};
		tests.push_back(t);
	endtask

	task automatic build_table();
		//        name                 sc1    sc2    sc3    sc4  slide  cursor  marker    x    y
		add_test("hs_low_656",         0,     0,     0,     0,   0, OFF,  0, OFF,  0, 656,   2, BG);
		add_test("hs_high_752",        0,     0,     0,     0,   0, OFF,  0, OFF,  0, 752,   2, BG);
		add_test("de_low_640",         0,     0,     0,     0,   0, OFF,  0, OFF,  0, 640,   3, BG);
		add_test("marker_visible",     0,     0,     0,     0,   0, OFF,  0,   9,  0, 600,   5, MARKER);
		add_test("marker_blanked",     0,     0,     0,     0,   0, OFF,  0,  10,  0, 700,   5, BG);
		add_test("cursor_cell",        0,     0,     0,     0,   0,   2, 15, OFF,  0, 140, 250, CURSOR);
		add_test("marker_cell",        0,     0,     0,     0,   0,   2, 15,   3, 15, 200, 250, MARKER);
		add_test("cursor_bottom_row",  0,     0,     0,     0,   0,   2, 15, OFF,  0, 140, 256, CURSOR);
		add_test("marker_over_cursor", 0,     0,     0,     0,   0,   3, 15,   3, 15, 200, 256, MARKER);
		add_test("track_left",         0,     0,     0,     0,  64, OFF,  0, OFF,  0, 150, 305, WHITE_KEY);
		add_test("knob_17",            0,     0,     0,     0,  17, OFF,  0, OFF,  0, 190, 305, KNOB);
		add_test("track_right_17",     0,     0,     0,     0,  17, OFF,  0, OFF,  0, 200, 305, WHITE_KEY);
		add_test("knob_64",            0,     0,     0,     0,  64, OFF,  0, OFF,  0, 410, 305, KNOB);
		add_test("track_right_64",     0,     0,     0,     0,  64, OFF,  0, OFF,  0, 421, 305, WHITE_KEY);
		add_test("black_over_white",   0,     0,     0,     0,   0, OFF,  0, OFF,  0,  15, 380, BLACK_KEY);
		add_test("white_gap",          0,     0,     0,     0,   0, OFF,  0, OFF,  0,  81, 380, BG);
		add_test("black_press_sc2",    0, 'h36,     0,     0,   0, OFF,  0, OFF,  0,   5, 425, BLACK_KEY);
		add_test("black_press_sc4",    0,     0,     0, 'h49,   0, OFF,  0, OFF,  0, 280, 425, BLACK_KEY);
		add_test("white_key_1",        0,     0,     0,     0,   0, OFF,  0, OFF,  0,  35, 430, WHITE_KEY);
		add_test("white_idle",         0,     0,     0,     0,   0, OFF,  0, OFF,  0,  85, 475, BG);
		add_test("white_press_sc3",    0,     0, 'h3c,     0,   0, OFF,  0, OFF,  0,  85, 475, WHITE_KEY);
		add_test("neighbour_idle",     0,     0, 'h3c,     0,   0, OFF,  0, OFF,  0, 110, 475, BG);
		add_test("white_press_sc1", 'h48,     0,     0,     0,   0, OFF,  0, OFF,  0, 260, 475, WHITE_KEY);
		add_test("vs_low_490",         0,     0,     0,     0,   0, OFF,  0, OFF,  0, 100, 490, BG);
	endtask

	task automatic apply_inputs(input probe_t t);
		@(posedge VGA_CLK);
		#1;
		scan_code1 = 8'(t.sc1);
		scan_code2 = 8'(t.sc2);
		scan_code3 = 8'(t.sc3);
		scan_code4 = 8'(t.sc4);
		slide_val  = 8'(t.slide);
		cursor_col = 4'(t.ccol);
		cursor_row = 4'(t.crow);
		marker_col = 4'(t.mcol);
		marker_row = 4'(t.mrow);
	endtask

	// Next edge registers raster index edge_cnt, probe may lie in the next frame
	task automatic wait_for_pixel(input int px, input int py);
		longint pos;
		longint ahead;
		longint target;
		pos    = edge_cnt % FRAME_CYCLES;
		ahead  = (longint'(py) * `H_TOTAL + px - pos + FRAME_CYCLES) % FRAME_CYCLES;
		target = edge_cnt + ahead + 1;
		@(negedge VGA_CLK);
		while (edge_cnt != target)
			@(negedge VGA_CLK);
	endtask

	task automatic check_color(input string name, input color_e exp);
		logic [8:0] pr;
		logic [8:0] pg;
		logic [8:0] pb;
		case (exp)
			BLACK_KEY: {pr, pg, pb} = {`PAL_BLACK_KEY_R, `PAL_BLACK_KEY_G, `PAL_BLACK_KEY_B};
			WHITE_KEY: {pr, pg, pb} = {`PAL_WHITE_KEY_R, `PAL_WHITE_KEY_G, `PAL_WHITE_KEY_B};
			CURSOR:    {pr, pg, pb} = {`PAL_CURSOR_R, `PAL_CURSOR_G, `PAL_CURSOR_B};
			KNOB:      {pr, pg, pb} = {`PAL_KNOB_R, `PAL_KNOB_G, `PAL_KNOB_B};
			MARKER:    {pr, pg, pb} = {`PAL_MARKER_R, `PAL_MARKER_G, `PAL_MARKER_B};
			default:   {pr, pg, pb} = {`PAL_BG_R, `PAL_BG_G, `PAL_BG_B};
		endcase
		if (vga_r !== {1'b0, pr} || vga_g !== {1'b0, pg} || vga_b !== {1'b0, pb}) begin
			$display("FAILED %s: rgb expected %s %h/%h/%h actual %h/%h/%h", name,
				exp.name(), {1'b0, pr}, {1'b0, pg}, {1'b0, pb}, vga_r, vga_g, vga_b);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input string sig, input logic exp,
	                         input logic act);
		if (act !== exp) begin
			$display("FAILED %s: %s expected %b actual %b", name, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_outputs(input string name, input color_e exp, input logic e_hs,
	                             input logic e_vs, input logic e_de);
		int errs_before;
		errs_before = errors;
		check_color(name, exp);
		check_bit(name, "hs", e_hs, hs);
		check_bit(name, "vs", e_vs, vs);
		check_bit(name, "de", e_de, de);
		tests_run++;
		if (errors != errs_before)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name, errors == errs_before ? "ok" : "mismatch");
	endtask

	initial begin : main
		probe_t t;
		logic   e_hs;
		logic   e_vs;
		logic   e_de;
		VGA_CLK    = 1'b0;
		reset      = 1'b1;
		scan_code1 = '0;
		scan_code2 = '0;
		scan_code3 = '0;
		scan_code4 = '0;
		slide_val  = '0;
		cursor_col = 4'(OFF);
		cursor_row = '0;
		marker_col = 4'(OFF);
		marker_row = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		build_table();

		repeat (2) @(posedge VGA_CLK);
		@(negedge VGA_CLK);
		check_outputs("reset_hold", BG, 1'b1, 1'b1, 1'b0);
		repeat (3) @(posedge VGA_CLK);
		#1 reset = 1'b0;
		@(negedge VGA_CLK); // Still the cleared register stage
		check_outputs("reset_release", BG, 1'b1, 1'b1, 1'b0);
		@(negedge VGA_CLK);
		check_outputs("first_pixel", BG, 1'b1, 1'b1, 1'b1);

		foreach (tests[i]) begin
			t = tests[i];
			apply_inputs(t);
			wait_for_pixel(t.px, t.py);
			e_hs = !(t.px >= `H_ACTIVE + `H_FRONT && t.px < `H_ACTIVE + `H_FRONT + `H_SYNC);
			e_vs = !(t.py >= `V_ACTIVE + `V_FRONT && t.py < `V_ACTIVE + `V_FRONT + `V_SYNC);
			e_de = (t.px < `H_ACTIVE) && (t.py < `V_ACTIVE);
			check_outputs(t.name, t.exp, e_hs, e_vs, e_de);
		end

		$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, errors, DUT.u_timing.u_chk.fail_count);
		if (errors == 0 && DUT.u_timing.u_chk.fail_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Worst case one frame per probe, plus margin for reset and the last frame
	initial begin : watchdog
		longint limit_ns;
		#1;
		limit_ns = (longint'(tests.size()) + 2) * FRAME_CYCLES * 20;
		#(limit_ns);
		$display("Timeout: probe pixels not reached within %0d ns", limit_ns);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+logic
logic/display_pkg.sv
logic/vga_timing.sv
logic/keyboard_painter.sv
logic/slider_painter.sv
logic/overlay_painter.sv
logic/pixel_mux.sv
logic/display_top.sv
verif/display_chk.sv
verif/display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sim.f --top-module display_tb -Mdir obj_dir -o display_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/display_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
